// File: bench/mips_testdata.txt
// columns: instruction word, expected wreg, expected address, expected data,
// expected illegal, then 1 for random idle gaps before the word or 0 for back-to-back
// after reset every register reads zero
00400825 1 01 00000000 0 0
03FE1825 1 03 00000000 0 0
00112025 1 04 00000000 0 0
// immediates, zero extended, lui ORs rs into the low half
34011234 1 01 00001234 0 1
3C02F0F0 1 02 F0F00000 0 1
344200FF 1 02 F0F000FF 0 1
30430F0F 1 03 0000000F 0 1
3844FFFF 1 04 F0F0FF00 0 1
30858001 1 05 00008000 0 1
3C068000 1 06 80000000 0 1
3C27ABCD 1 07 ABCD1234 0 1
00204025 1 08 00001234 0 1
// three-register logic, immediate and variable shifts
00444824 1 09 F0F00000 0 1
00445025 1 0A F0F0FFFF 0 1
00445826 1 0B 0000FFFF 0 1
00446027 1 0C 0F0F0000 0 1
00016900 1 0D 00012340 0 1
000677C2 1 0E 00000001 0 1
00067903 1 0F F8000000 0 1
00018103 1 10 00000123 0 1
00678804 1 11 891A0000 0 1
00249006 1 12 00000F0F 0 1
00669807 1 13 FFFF0000 0 1
00A2A007 1 14 F0F000FF 0 1
// dependent chain back-to-back, distance one and two
341500F0 1 15 000000F0 0 0
0015B200 1 16 0000F000 0 0
02B6B825 1 17 0000F0F0 0 0
3AF7FFFF 1 17 00000F0F 0 0
02F6C027 1 18 FFFF00F0 0 0
02B8C807 1 19 FFFFFFFF 0 0
0338D024 1 1A FFFF00F0 0 0
001AD902 1 1B 0FFFF00F 0 0
// same chain with random gaps
341500F0 1 15 000000F0 0 1
0015B200 1 16 0000F000 0 1
02B6B825 1 17 0000F0F0 0 1
3AF7FFFF 1 17 00000F0F 0 1
02F6C027 1 18 FFFF00F0 0 1
02B8C807 1 19 FFFFFFFF 0 1
0338D024 1 1A FFFF00F0 0 1
001AD902 1 1B 0FFFF00F 0 1
// r0 writes, illegal words, bubbles, then registers read back unchanged
34205555 1 00 00005775 0 0
0000E025 1 1C 00000000 0 0
0022E820 0 00 00000000 1 0
8C3D0000 0 00 00000000 1 0
00000000 0 00 00000000 0 0
00000040 0 00 00000000 0 0
0000000F 0 00 00000000 0 0
CC220010 0 00 00000000 0 0
7C000000 0 00 00000000 1 0
03A0F025 1 1E 00000000 0 0
02E0F825 1 1F 00000F0F 0 0
0004E024 1 1C 00000000 0 0

// File: bench/tb_mips_logic_core.sv
`timescale 1ns/1ps

module tb_mips_logic_core;
    import mips_pkg::*;

    localparam int MAX_ROWS       = 128;
    localparam int COLS           = 6;   // values per row in the data file
    localparam int LATENCY        = 2;
    localparam int RESULT_TIMEOUT = 10;
    localparam int DRAIN_TIMEOUT  = 20;

    // one expected write-back, plus how it is sent
    typedef struct packed {
        logic [31:0] inst;
        logic        wreg;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        illegal;
        logic        gap;
        logic [31:0] sent;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    inst_u       inst;
    logic        wb_valid;
    logic        wb_wreg;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] stim [COLS*MAX_ROWS];
    expect_t     exp_q [$];
    int          cycle;
    int          rows;
    int          checks;
    int          mismatches;
    int          missing;
    int          extra;
    int          load_errors;

    mips_logic_core UUT (
        .clk          (clk),
        .reset_i      (reset),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .wb_valid_o   (wb_valid),
        .wb_wreg_o    (wb_wreg),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data),
        .illegal_o    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_field(input string name, input logic [31:0] word,
                                 input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("Fail at %0t ns: inst %h, %s is %h, expected %h",
                     $time, word, name, got, want);
            mismatches++;
        end
    endtask

    // compares one write-back pulse against the oldest outstanding instruction
    task automatic check_writeback;
        expect_t e;
        if (wb_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected write-back result at %0t ns with nothing outstanding",
                         $time);
                extra++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                compare_field("latency", e.inst, cycle - e.sent, LATENCY);
                compare_field("wb_wreg_o", e.inst, wb_wreg, e.wreg);
                compare_field("illegal_o", e.inst, illegal, e.illegal);
                if (e.wreg) begin   // address and data only mean something on a write
                    compare_field("wb_addr_o", e.inst, wb_addr, e.addr);
                    compare_field("wb_data_o", e.inst, wb_data, e.data);
                end
            end
        end else if (exp_q.size() != 0) begin
            e = exp_q[0];
            assert (cycle - e.sent <= RESULT_TIMEOUT) else begin
                $display("Instruction %h got no write-back result within %0d cycles",
                         e.inst, RESULT_TIMEOUT);
                missing++;
                e = exp_q.pop_front();
            end
        end
    endtask

    task automatic tick;
        @(negedge clk);
        cycle++;
        check_writeback();
    endtask

    task automatic idle_cycle;
        tick();
        inst_valid = 1'b0;
        inst       = '0;
    endtask

    task automatic send_instruction(input expect_t e);
        expect_t q;
        tick();
        inst_valid = 1'b1;
        inst       = e.inst;
        q          = e;
        q.sent     = cycle;
        exp_q.push_back(q);
    endtask

    function automatic expect_t row_entry(input int r);
        expect_t e;
        e.inst    = stim[COLS*r];
        e.wreg    = stim[COLS*r+1][0];
        e.addr    = stim[COLS*r+2][4:0];
        e.data    = stim[COLS*r+3];
        e.illegal = stim[COLS*r+4][0];
        e.gap     = stim[COLS*r+5][0];
        e.sent    = '0;
        return e;
    endfunction

    initial begin
        int      gaps;
        int      waited;
        expect_t e;

        void'($urandom(3780));
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        cycle       = 0;
        checks      = 0;
        mismatches  = 0;
        missing     = 0;
        extra       = 0;
        load_errors = 0;

        $readmemh("bench/mips_testdata.txt", stim);
        rows = 0;
        while (rows < MAX_ROWS && !$isunknown(stim[COLS*rows])) begin
            rows++;
        end
        assert (rows > 0) else begin
            $display("No test rows could be loaded from bench/mips_testdata.txt");
            load_errors++;
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        checks++;
        assert (wb_valid === 1'b0 && wb_wreg === 1'b0 && illegal === 1'b0) else begin
            $display("Fail at %0t ns: write-back outputs active right after reset", $time);
            mismatches++;
        end

        for (int r = 0; r < rows; r++) begin
            e = row_entry(r);
            if (e.gap) begin
                gaps = $urandom % 4;   // 0 to 3 idle cycles
                repeat (gaps) idle_cycle();
            end
            send_instruction(e);
        end

        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            idle_cycle();
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d instructions never produced a write-back result", exp_q.size());
            missing += exp_q.size();
        end
        repeat (4) idle_cycle();   // anything arriving now is extra

        $display("rows %0d, checks %0d, mismatches %0d, missing %0d, extra %0d, load errors %0d",
                 rows, checks, mismatches, missing, extra, load_errors);
        if (mismatches == 0 && missing == 0 && extra == 0 && load_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic             clk,
    input  logic             reset_i,
    input  mips_pkg::id_ex_t id_ex_i,
    output mips_pkg::fwd_t   fwd_o,
    output mips_pkg::ex_wb_t ex_wb_o
);
    import mips_pkg::*;

    logic [31:0] logic_res;
    logic [31:0] shift_res;
    logic [31:0] result;
    logic [4:0]  sa;
    ex_wb_t      ex_wb_q;

    assign sa = id_ex_i.op2[4:0];   // only low 5 bits count

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_AND: logic_res = id_ex_i.op1 & id_ex_i.op2;
            ALU_OR:  logic_res = id_ex_i.op1 | id_ex_i.op2;
            ALU_XOR: logic_res = id_ex_i.op1 ^ id_ex_i.op2;
            ALU_NOR: logic_res = ~(id_ex_i.op1 | id_ex_i.op2);
            default: logic_res = 32'd0;
        endcase
    end

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SLL: shift_res = id_ex_i.op1 << sa;
            ALU_SRL: shift_res = id_ex_i.op1 >> sa;
            ALU_SRA: shift_res = $unsigned($signed(id_ex_i.op1) >>> sa);   // sign fill
            default: shift_res = 32'd0;
        endcase
    end

    always_comb begin
        case (id_ex_i.alu_sel)
            SEL_LOGIC: result = logic_res;
            SEL_SHIFT: result = shift_res;
            default:   result = 32'd0;
        endcase
    end

    // back to decode before the edge, covers distance-one hazards
    assign fwd_o.wreg  = id_ex_i.valid & id_ex_i.wreg;
    assign fwd_o.waddr = id_ex_i.waddr;
    assign fwd_o.data  = result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_wb_q.valid   <= 1'b0;
            ex_wb_q.illegal <= 1'b0;
            ex_wb_q.wreg    <= 1'b0;
        end else begin
            ex_wb_q.valid   <= id_ex_i.valid;
            ex_wb_q.illegal <= id_ex_i.illegal;
            ex_wb_q.wreg    <= id_ex_i.valid & id_ex_i.wreg;
            ex_wb_q.waddr   <= id_ex_i.waddr;
            ex_wb_q.data    <= result;
        end
    end

    assign ex_wb_o = ex_wb_q;

    // decode pairs a shift select only with a shift operation
    shift_op_check: assert property (@(posedge clk) disable iff (reset_i)
        id_ex_i.valid && id_ex_i.alu_sel == SEL_SHIFT
            |-> id_ex_i.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA});

endmodule

// File: hdl/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             inst_valid_i,
    input  mips_pkg::inst_u  inst_i,
    input  logic [31:0]      rd1_data_i,
    input  logic [31:0]      rd2_data_i,
    input  mips_pkg::fwd_t   fwd_i,
    output logic [4:0]       rd1_addr_o,
    output logic [4:0]       rd2_addr_o,
    output logic             rd1_en_o,
    output logic             rd2_en_o,
    output mips_pkg::id_ex_t id_ex_o
);
    import mips_pkg::*;

    alu_sel_e    sel;
    alu_op_e     op;
    logic [4:0]  waddr;
    logic        wreg;
    logic        illegal;
    logic        rd1_en;
    logic        rd2_en;
    logic [4:0]  rd1_addr;
    logic [4:0]  rd2_addr;
    logic [31:0] imm32;
    logic        use_imm;   // operand 2 comes from the instruction word
    logic        hit1;
    logic        hit2;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;

    // and/or/xor/nor share low bits between func and the immediate opcodes
    function automatic alu_op_e logic_op(input logic [1:0] code);
        case (code)
            2'b00:   return ALU_AND;
            2'b01:   return ALU_OR;
            2'b10:   return ALU_XOR;
            default: return ALU_NOR;
        endcase
    endfunction

    // same trick for sll/srl/sra and their variable forms
    function automatic alu_op_e shift_op(input logic [1:0] code);
        case (code)
            2'b10:   return ALU_SRL;
            2'b11:   return ALU_SRA;
            default: return ALU_SLL;
        endcase
    endfunction

    always_comb begin
        sel      = SEL_NOP;
        op       = ALU_NOP;
        waddr    = 5'd0;
        wreg     = 1'b0;
        illegal  = 1'b0;
        rd1_en   = 1'b0;
        rd2_en   = 1'b0;
        rd1_addr = 5'd0;
        rd2_addr = 5'd0;
        imm32    = 32'd0;
        use_imm  = 1'b0;

        case (inst_i.r.op)
            OP_SPECIAL: begin
                case (inst_i.r.func)
                    FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR: begin
                        if (inst_i.r.shamt != 5'd0) begin
                            illegal = 1'b1;
                        end else begin
                            sel      = SEL_LOGIC;
                            op       = logic_op(inst_i.r.func[1:0]);
                            waddr    = inst_i.r.rd;
                            wreg     = 1'b1;
                            rd1_en   = 1'b1;
                            rd1_addr = inst_i.r.rs;
                            rd2_en   = 1'b1;
                            rd2_addr = inst_i.r.rt;
                        end
                    end
                    FUNC_SLLV, FUNC_SRLV, FUNC_SRAV: begin
                        if (inst_i.r.shamt != 5'd0) begin
                            illegal = 1'b1;
                        end else begin
                            sel      = SEL_SHIFT;
                            op       = shift_op(inst_i.r.func[1:0]);
                            waddr    = inst_i.r.rd;
                            wreg     = 1'b1;
                            rd1_en   = 1'b1;
                            rd1_addr = inst_i.r.rt;   // value to shift
                            rd2_en   = 1'b1;
                            rd2_addr = inst_i.r.rs;   // amount
                        end
                    end
                    FUNC_SLL, FUNC_SRL, FUNC_SRA: begin
                        // sll with all fields zero and shamt 0 or 1 is nop / ssnop
                        if (inst_i.r.func != FUNC_SLL || inst_i.r.rs != 5'd0 ||
                            inst_i.r.rt != 5'd0 || inst_i.r.rd != 5'd0 ||
                            inst_i.r.shamt > 5'd1) begin
                            sel      = SEL_SHIFT;
                            op       = shift_op(inst_i.r.func[1:0]);
                            waddr    = inst_i.r.rd;
                            wreg     = 1'b1;
                            rd1_en   = 1'b1;
                            rd1_addr = inst_i.r.rt;
                            use_imm  = 1'b1;
                            imm32    = {27'd0, inst_i.r.shamt};
                        end
                    end
                    FUNC_SYNC: begin
                        // bubble, nothing to order in this core
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                sel      = SEL_LOGIC;
                op       = logic_op(inst_i.i.op[1:0]);
                waddr    = inst_i.i.rt;
                wreg     = 1'b1;
                rd1_en   = 1'b1;
                rd1_addr = inst_i.i.rs;
                use_imm  = 1'b1;
                imm32    = {16'd0, inst_i.i.imm16};   // zero extend
            end
            OP_LUI: begin
                sel      = SEL_LOGIC;
                op       = ALU_OR;                    // rs | imm << 16
                waddr    = inst_i.i.rt;
                wreg     = 1'b1;
                rd1_en   = 1'b1;
                rd1_addr = inst_i.i.rs;
                use_imm  = 1'b1;
                imm32    = {inst_i.i.imm16, 16'd0};
            end
            OP_PREF: begin
                // hint only, runs as a bubble
            end
            default: illegal = 1'b1;
        endcase
    end

    // execute result wins over the register file path
    assign hit1 = fwd_i.wreg && rd1_en && (rd1_addr != 5'd0) && (fwd_i.waddr == rd1_addr);
    assign hit2 = fwd_i.wreg && rd2_en && (rd2_addr != 5'd0) && (fwd_i.waddr == rd2_addr);

    assign rd1_addr_o = rd1_addr;
    assign rd2_addr_o = rd2_addr;
    assign rd1_en_o   = rd1_en & inst_valid_i;
    assign rd2_en_o   = rd2_en & inst_valid_i;

    always_comb begin
        id_ex_d.valid   = inst_valid_i;
        id_ex_d.illegal = illegal & inst_valid_i;
        id_ex_d.wreg    = wreg & inst_valid_i;
        id_ex_d.alu_sel = sel;
        id_ex_d.alu_op  = op;
        id_ex_d.waddr   = waddr;
        id_ex_d.op1     = hit1 ? fwd_i.data : rd1_data_i;
        id_ex_d.op2     = use_imm ? imm32 : (hit2 ? fwd_i.data : rd2_data_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q.valid   <= 1'b0;
            id_ex_q.illegal <= 1'b0;
            id_ex_q.wreg    <= 1'b0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

    // an illegal word still completes, but never writes
    illegal_no_write: assert property (@(posedge clk) disable iff (reset_i)
        id_ex_q.illegal |-> id_ex_q.valid && !id_ex_q.wreg);

endmodule

// File: hdl/mips_logic_core.sv
`timescale 1ns/1ps

module mips_logic_core (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            inst_valid_i,   // one pulse per instruction
    input  mips_pkg::inst_u inst_i,
    output logic            wb_valid_o,
    output logic            wb_wreg_o,
    output logic [4:0]      wb_addr_o,
    output logic [31:0]     wb_data_o,
    output logic            illegal_o
);
    import mips_pkg::*;

    logic [4:0]  rd1_addr;
    logic [4:0]  rd2_addr;
    logic        rd1_en;
    logic        rd2_en;
    logic [31:0] rd1_data;
    logic [31:0] rd2_data;
    id_ex_t      id_ex;
    ex_wb_t      ex_wb;
    fwd_t        fwd;

    inst_decode u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rd1_data_i   (rd1_data),
        .rd2_data_i   (rd2_data),
        .fwd_i        (fwd),
        .rd1_addr_o   (rd1_addr),
        .rd2_addr_o   (rd2_addr),
        .rd1_en_o     (rd1_en),
        .rd2_en_o     (rd2_en),
        .id_ex_o      (id_ex)
    );

    alu_execute u_execute (
        .clk     (clk),
        .reset_i (reset_i),
        .id_ex_i (id_ex),
        .fwd_o   (fwd),
        .ex_wb_o (ex_wb)
    );

    // register file also drives the write-back port
    reg_file_writeback u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd1_addr_i (rd1_addr),
        .rd2_addr_i (rd2_addr),
        .rd1_en_i   (rd1_en),
        .rd2_en_i   (rd2_en),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data),
        .ex_wb_i    (ex_wb),
        .wb_valid_o (wb_valid_o),
        .wb_wreg_o  (wb_wreg_o),
        .illegal_o  (illegal_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    // register-type view of an instruction word
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } r_fields_t;

    // immediate-type view of the same word
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    typedef enum logic [1:0] {
        SEL_NOP   = 2'b00,
        SEL_LOGIC = 2'b01,
        SEL_SHIFT = 2'b10
    } alu_sel_e;

    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_AND = 3'd1,
        ALU_OR  = 3'd2,
        ALU_XOR = 3'd3,
        ALU_NOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SRA = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        alu_sel_e    alu_sel;
        alu_op_e     alu_op;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [4:0]  waddr;
        logic        wreg;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        wreg;
        logic [4:0]  waddr;
        logic [31:0] data;
    } ex_wb_t;

    // execute result offered back to decode in the same cycle
    typedef struct packed {
        logic        wreg;
        logic [4:0]  waddr;
        logic [31:0] data;
    } fwd_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_PREF    = 6'h33;

    localparam logic [5:0] FUNC_AND  = 6'h24;
    localparam logic [5:0] FUNC_OR   = 6'h25;
    localparam logic [5:0] FUNC_XOR  = 6'h26;
    localparam logic [5:0] FUNC_NOR  = 6'h27;
    localparam logic [5:0] FUNC_SLLV = 6'h04;
    localparam logic [5:0] FUNC_SRLV = 6'h06;
    localparam logic [5:0] FUNC_SRAV = 6'h07;
    localparam logic [5:0] FUNC_SYNC = 6'h0f;
    localparam logic [5:0] FUNC_SLL  = 6'h00; // also nop and ssnop
    localparam logic [5:0] FUNC_SRL  = 6'h02;
    localparam logic [5:0] FUNC_SRA  = 6'h03;

endpackage

// File: hdl/reg_file_writeback.sv
`timescale 1ns/1ps

module reg_file_writeback (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [4:0]       rd1_addr_i,
    input  logic [4:0]       rd2_addr_i,
    input  logic             rd1_en_i,
    input  logic             rd2_en_i,
    output logic [31:0]      rd1_data_o,
    output logic [31:0]      rd2_data_o,
    input  mips_pkg::ex_wb_t ex_wb_i,
    output logic             wb_valid_o,
    output logic             wb_wreg_o,
    output logic             illegal_o,
    output logic [4:0]       wb_addr_o,
    output logic [31:0]      wb_data_o
);
    import mips_pkg::*;

    logic [31:0] regs [32];
    logic        we;

    assign we = ex_wb_i.valid && ex_wb_i.wreg && (ex_wb_i.waddr != 5'd0);   // r0 stays zero

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we) begin
            regs[ex_wb_i.waddr] <= ex_wb_i.data;
        end
    end

    // write-through so a distance-two reader sees this cycle's write
    always_comb begin
        if (!rd1_en_i || rd1_addr_i == 5'd0) begin
            rd1_data_o = 32'd0;
        end else if (we && ex_wb_i.waddr == rd1_addr_i) begin
            rd1_data_o = ex_wb_i.data;
        end else begin
            rd1_data_o = regs[rd1_addr_i];
        end
    end

    always_comb begin
        if (!rd2_en_i || rd2_addr_i == 5'd0) begin
            rd2_data_o = 32'd0;
        end else if (we && ex_wb_i.waddr == rd2_addr_i) begin
            rd2_data_o = ex_wb_i.data;
        end else begin
            rd2_data_o = regs[rd2_addr_i];
        end
    end

    assign wb_valid_o = ex_wb_i.valid;
    assign wb_wreg_o  = ex_wb_i.wreg;
    assign illegal_o  = ex_wb_i.illegal;
    assign wb_addr_o  = ex_wb_i.waddr;
    assign wb_data_o  = ex_wb_i.data;

    write_addr_known: assert property (@(posedge clk) disable iff (reset_i)
        ex_wb_i.valid && ex_wb_i.wreg |-> !$isunknown(ex_wb_i.waddr));

endmodule

// File: mips_logic_core.f
hdl/mips_pkg.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/reg_file_writeback.sv
hdl/mips_logic_core.sv
bench/tb_mips_logic_core.sv
